// File: rtl/vrf_pkg.sv
`default_nettype none

package vrf_pkg;

  ////////////////////////////////////////
  // Register file geometry
  ////////////////////////////////////////

  // Number of architectural vector registers
  localparam int NrVregs = 32;

  // Word width of a single register
  localparam int VrfWordWidth = 128;

  // Byte lanes per word
  localparam int VrfWordBytes = VrfWordWidth / 8;

  ////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////

  typedef logic [$clog2(NrVregs)-1:0] vreg_addr_t;
  typedef logic [VrfWordWidth-1:0]    vrf_data_t;
  // One enable per byte lane
  typedef logic [VrfWordBytes-1:0]    vrf_strb_t;

  ////////////////////////////////////////
  // Request and tracking structs
  ////////////////////////////////////////

  // Byte-masked write request
  typedef struct packed {
    vreg_addr_t addr;
    vrf_data_t  data;
    vrf_strb_t  strb;
  } vrf_wreq_t;

  // One write still on its way into the array
  typedef struct packed {
    logic       valid;
    vreg_addr_t addr;
  } vrf_pending_t;

endpackage

`default_nettype wire

// File: rtl/vrf_clk_gate.sv
`timescale 1ns/1ps
`default_nettype none

module vrf_clk_gate (
  input  logic clk,
  input  logic en_i,
  output logic clk_o
);

  // Enable held while the clock is high
  logic en_q;

  // Transparent in the low phase only, so clk_o cannot glitch
  always_latch begin
    if (!clk) begin
      en_q <= en_i;
    end
  end

  assign clk_o = clk & en_q;

endmodule

`default_nettype wire

// File: rtl/vregfile.sv
`timescale 1ns/1ps
`default_nettype none

module vregfile import vrf_pkg::*; #(
  parameter int unsigned NrReadPorts = 1
) (
  input  logic                         clk,
  // Write side
  input  vreg_addr_t                   waddr_i,
  input  vrf_data_t                    wdata_i,
  input  logic                         we_i,
  input  vrf_strb_t                    wbe_i,
  // Read side
  input  vreg_addr_t [NrReadPorts-1:0] raddr_i,
  input  logic       [NrReadPorts-1:0] re_i,
  output vrf_data_t  [NrReadPorts-1:0] rdata_o
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  // Clock of the whole array, runs only on writes
  logic clk_wr;

  // Storage, one byte latch per lane
  logic [NrVregs-1:0][VrfWordBytes-1:0][7:0] mem;

  // Sampled write data
  vrf_data_t wdata_q;

  // Which byte latches open this write
  logic [NrVregs-1:0][VrfWordBytes-1:0] wsel;

  ////////////////////////////////////////
  // Write path
  ////////////////////////////////////////

  vrf_clk_gate u_top_cg (
    .clk   (clk),
    .en_i  (we_i),
    .clk_o (clk_wr)
  );

  // Data stays put while the latches are open
  always_ff @(posedge clk_wr) begin
    wdata_q <= wdata_i;
  end

  for (genvar r = 0; r < NrVregs; r++) begin : gen_vreg
    for (genvar b = 0; b < VrfWordBytes; b++) begin : gen_byte
      // Clock of this byte latch
      logic       clk_byte;
      logic [7:0] byte_q;

      // One-hot over register and byte lane
      assign wsel[r][b] = we_i && wbe_i[b] && (waddr_i == vreg_addr_t'(r));

      // Enable captured in the low phase of clk_wr
      vrf_clk_gate u_byte_cg (
        .clk   (clk_wr),
        .en_i  (wsel[r][b]),
        .clk_o (clk_byte)
      );

      // Open during the high phase after the sample edge
      always_latch begin
        if (clk_byte) begin
          byte_q <= wdata_q[b*8 +: 8];
        end
      end

      assign mem[r][b] = byte_q;
    end
  end

  ////////////////////////////////////////
  // Read path
  ////////////////////////////////////////

  // Combinational, zero while the port is idle
  for (genvar p = 0; p < NrReadPorts; p++) begin : gen_rport
    assign rdata_o[p] = re_i[p] ? mem[raddr_i[p]] : '0;
  end

  // A write with no lane enabled would leave the tracker and array out of step
  a_we_has_strb : assert property (@(posedge clk) we_i |-> (wbe_i != '0))
    else $error("vregfile: write enable with empty byte mask");

endmodule

`default_nettype wire

// File: rtl/vrf_write_port.sv
`timescale 1ns/1ps
`default_nettype none

module vrf_write_port import vrf_pkg::*; (
  input  logic         clk,
  input  logic         arst_n_i,
  // Request side
  input  logic         wreq_valid_i,
  output logic         wreq_ready_o,
  input  vrf_wreq_t    wreq_i,
  // Register file side
  output logic         we_o,
  output vreg_addr_t   waddr_o,
  output vrf_data_t    wdata_o,
  output vrf_strb_t    wbe_o,
  // Writes in flight
  output vrf_pending_t pend_s1_o,
  output vrf_pending_t pend_s2_o
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  logic       ready_q;
  logic       accept;

  // Stage one, presented to the array
  logic       s1_valid_q;
  vrf_wreq_t  s1_req_q;

  // Stage two, latches open this cycle
  logic       s2_valid_q;
  vreg_addr_t s2_addr_q;

  // Never stalls, ready only waits for reset release
  assign wreq_ready_o = ready_q;
  assign accept       = wreq_valid_i && ready_q;

  ////////////////////////////////////////
  // Pipeline
  ////////////////////////////////////////

  // Control state
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ready_q    <= 1'b0;
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      ready_q    <= 1'b1;
      s1_valid_q <= accept;
      s2_valid_q <= s1_valid_q;
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (accept) begin
      s1_req_q <= wreq_i;
    end
    s2_addr_q <= s1_req_q.addr;
  end

  // Array inputs straight from stage one
  assign we_o    = s1_valid_q;
  assign waddr_o = s1_req_q.addr;
  assign wdata_o = s1_req_q.data;
  assign wbe_o   = s1_req_q.strb;

  // Hazard info for the read ports
  assign pend_s1_o = '{valid: s1_valid_q, addr: s1_req_q.addr};
  assign pend_s2_o = '{valid: s2_valid_q, addr: s2_addr_q};

  // Requester must hold its payload until taken
  a_wreq_stable : assert property (@(posedge clk) disable iff (!arst_n_i)
    (wreq_valid_i && !wreq_ready_o) |=> (wreq_valid_i && $stable(wreq_i)))
    else $error("vrf_write_port: write request changed before transfer");

endmodule

`default_nettype wire

// File: rtl/vrf_read_port.sv
`timescale 1ns/1ps
`default_nettype none

module vrf_read_port import vrf_pkg::*; (
  input  logic         clk,
  input  logic         arst_n_i,
  // Request side
  input  logic         rreq_valid_i,
  output logic         rreq_ready_o,
  input  vreg_addr_t   rreq_addr_i,
  // Response side
  output logic         rrsp_valid_o,
  input  logic         rrsp_ready_i,
  output vrf_data_t    rrsp_data_o,
  // Writes in flight
  input  vrf_pending_t pend_s1_i,
  input  vrf_pending_t pend_s2_i,
  // Register file side
  output vreg_addr_t   raddr_o,
  output logic         re_o,
  input  vrf_data_t    rdata_i
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  logic      hazard;
  logic      slot_free;
  logic      accept;

  // Response register
  logic      rsp_valid_q;
  vrf_data_t rsp_data_q;

  ////////////////////////////////////////
  // Request acceptance
  ////////////////////////////////////////

  // Target still being written and not yet final in the array
  assign hazard = (pend_s1_i.valid && (pend_s1_i.addr == rreq_addr_i)) ||
                  (pend_s2_i.valid && (pend_s2_i.addr == rreq_addr_i));

  // Slot empty or drained this cycle
  assign slot_free = !rsp_valid_q || rrsp_ready_i;

  assign rreq_ready_o = slot_free && !hazard;
  assign accept       = rreq_valid_i && rreq_ready_o;

  // Array read in the acceptance cycle
  assign raddr_o = rreq_addr_i;
  assign re_o    = accept;

  ////////////////////////////////////////
  // Response
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (rrsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // Data captured at the acceptance edge
  always_ff @(posedge clk) begin
    if (accept) begin
      rsp_data_q <= rdata_i;
    end
  end

  assign rrsp_valid_o = rsp_valid_q;
  assign rrsp_data_o  = rsp_data_q;

endmodule

`default_nettype wire

// File: rtl/vrf_top.sv
`timescale 1ns/1ps
`default_nettype none

module vrf_top import vrf_pkg::*; #(
  parameter int unsigned NrReadPorts = 2
) (
  input  logic                         clk,
  input  logic                         arst_n_i,
  // Write request
  input  logic                         wreq_valid_i,
  output logic                         wreq_ready_o,
  input  vrf_wreq_t                    wreq_i,
  // Read requests, one per port
  input  logic       [NrReadPorts-1:0] rreq_valid_i,
  output logic       [NrReadPorts-1:0] rreq_ready_o,
  input  vreg_addr_t [NrReadPorts-1:0] rreq_addr_i,
  // Read responses, one per port
  output logic       [NrReadPorts-1:0] rrsp_valid_o,
  input  logic       [NrReadPorts-1:0] rrsp_ready_i,
  output vrf_data_t  [NrReadPorts-1:0] rrsp_data_o
);

  ////////////////////////////////////////
  // Interconnect
  ////////////////////////////////////////

  // Write port to array
  logic         we;
  vreg_addr_t   waddr;
  vrf_data_t    wdata;
  vrf_strb_t    wbe;

  // Writes in flight, seen by every read port
  vrf_pending_t pend_s1;
  vrf_pending_t pend_s2;

  // Read ports to array
  vreg_addr_t [NrReadPorts-1:0] raddr;
  logic       [NrReadPorts-1:0] re;
  vrf_data_t  [NrReadPorts-1:0] rdata;

  vrf_write_port u_write_port (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .wreq_valid_i (wreq_valid_i),
    .wreq_ready_o (wreq_ready_o),
    .wreq_i       (wreq_i),
    .we_o         (we),
    .waddr_o      (waddr),
    .wdata_o      (wdata),
    .wbe_o        (wbe),
    .pend_s1_o    (pend_s1),
    .pend_s2_o    (pend_s2)
  );

  for (genvar p = 0; p < NrReadPorts; p++) begin : gen_read_port
    vrf_read_port u_read_port (
      .clk          (clk),
      .arst_n_i     (arst_n_i),
      .rreq_valid_i (rreq_valid_i[p]),
      .rreq_ready_o (rreq_ready_o[p]),
      .rreq_addr_i  (rreq_addr_i[p]),
      .rrsp_valid_o (rrsp_valid_o[p]),
      .rrsp_ready_i (rrsp_ready_i[p]),
      .rrsp_data_o  (rrsp_data_o[p]),
      .pend_s1_i    (pend_s1),
      .pend_s2_i    (pend_s2),
      .raddr_o      (raddr[p]),
      .re_o         (re[p]),
      .rdata_i      (rdata[p])
    );
  end

  // Latch array
  vregfile #(
    .NrReadPorts (NrReadPorts)
  ) u_vregfile (
    .clk     (clk),
    .waddr_i (waddr),
    .wdata_i (wdata),
    .we_i    (we),
    .wbe_i   (wbe),
    .raddr_i (raddr),
    .re_i    (re),
    .rdata_o (rdata)
  );

endmodule

`default_nettype wire

// File: tb/tb_vrf_model.svh
`ifndef TB_VRF_MODEL_SVH
`define TB_VRF_MODEL_SVH

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Architectural contents, updated at the accepting edge
  vrf_data_t  model_mem [NrVregs];

  // Writes accepted on the last two edges, newest first
  logic       fl_valid [2];
  vreg_addr_t fl_addr  [2];

  function automatic void model_clear();
    for (int r = 0; r < NrVregs; r++) begin
      model_mem[r] = '0;
    end
    fl_valid[0] = 1'b0;
    fl_valid[1] = 1'b0;
  endfunction

  // Only enabled lanes change
  function automatic void model_write(vreg_addr_t addr, vrf_data_t data, vrf_strb_t strb);
    for (int b = 0; b < VrfWordBytes; b++) begin
      if (strb[b]) begin
        model_mem[addr][b*8 +: 8] = data[b*8 +: 8];
      end
    end
  endfunction

  // In stage one or two, array not yet updated
  function automatic logic model_busy(vreg_addr_t addr);
    return (fl_valid[0] && (fl_addr[0] == addr)) || (fl_valid[1] && (fl_addr[1] == addr));
  endfunction

  // Once per rising edge
  function automatic void model_advance(logic acc, vreg_addr_t addr);
    fl_valid[1] = fl_valid[0];
    fl_addr[1]  = fl_addr[0];
    fl_valid[0] = acc;
    fl_addr[0]  = addr;
  endfunction

`endif

// File: tb/tb_vrf_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vrf_top import vrf_pkg::*; ();

  localparam int NrPorts    = 2;
  localparam int MaskCycles = 400;
  localparam int RawCycles  = 300;
  localparam int BpCycles   = 600;
  localparam int RandCycles = 2000;
  // Directed writes and read pairs, then the random phases
  localparam int TxnCount   = 4 * NrVregs + 16 + MaskCycles + RawCycles + BpCycles + RandCycles;

  logic                     clk;
  logic                     arst_n;
  logic                     wreq_valid;
  logic                     wreq_ready;
  vrf_wreq_t                wreq;
  logic       [NrPorts-1:0] rreq_valid;
  logic       [NrPorts-1:0] rreq_ready;
  vreg_addr_t [NrPorts-1:0] rreq_addr;
  logic       [NrPorts-1:0] rrsp_valid;
  logic       [NrPorts-1:0] rrsp_ready;
  vrf_data_t  [NrPorts-1:0] rrsp_data;

  // Stimulus applied at the next falling edge
  logic                     nxt_wvalid;
  vrf_wreq_t                nxt_wreq;
  logic       [NrPorts-1:0] nxt_rvalid;
  vreg_addr_t [NrPorts-1:0] nxt_raddr;
  logic       [NrPorts-1:0] nxt_rrdy;

  // Scoreboard
  vrf_data_t                exp_q [NrPorts][$];
  logic       [NrPorts-1:0] acc_prev;
  logic       [NrPorts-1:0] hold_prev;
  vrf_data_t                held_data [NrPorts];
  int                       err_count;
  int                       check_count;
  int                       test_errs;
  string                    test_name;

  `include "tb_vrf_model.svh"

  vrf_top #(
    .NrReadPorts (NrPorts)
  ) u_dut (
    .clk          (clk),
    .arst_n_i     (arst_n),
    .wreq_valid_i (wreq_valid),
    .wreq_ready_o (wreq_ready),
    .wreq_i       (wreq),
    .rreq_valid_i (rreq_valid),
    .rreq_ready_o (rreq_ready),
    .rreq_addr_i  (rreq_addr),
    .rrsp_valid_o (rrsp_valid),
    .rrsp_ready_i (rrsp_ready),
    .rrsp_data_o  (rrsp_data)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  // Watchdog
  initial begin
    repeat (TxnCount * 20) @(posedge clk);
    $display("ERROR: watchdog expired after %0d cycles, run did not complete", TxnCount * 20);
    $display("Some tests failed");
    $finish;
  end

  ////////////////////////////////////////
  // Checking
  ////////////////////////////////////////

  task automatic check_value(input string what, input vrf_data_t exp, input vrf_data_t act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("[FAIL] %s %s: expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic report_error(input string msg);
    err_count++;
    $display("ERROR: %s: %s", test_name, msg);
  endtask

  // Runs just before the rising edge, books what that edge transfers
  task automatic observe();
    logic      exp_rdy;
    logic      r_acc;
    vrf_data_t exp;
    for (int p = 0; p < NrPorts; p++) begin
      // Latency is exactly one cycle
      if (acc_prev[p] && !rrsp_valid[p]) begin
        report_error($sformatf("port %0d response missing one cycle after acceptance", p));
      end
      if (rrsp_valid[p] && exp_q[p].size() == 0) begin
        report_error($sformatf("port %0d response without an accepted request", p));
      end else if (!rrsp_valid[p] && exp_q[p].size() != 0) begin
        report_error($sformatf("port %0d response lost", p));
        exp_q[p].delete();
      end
      if (hold_prev[p]) begin
        check_value($sformatf("port %0d stalled data", p), held_data[p], rrsp_data[p]);
      end
      if (rrsp_valid[p] && rrsp_ready[p] && exp_q[p].size() != 0) begin
        exp = exp_q[p].pop_front();
        check_value($sformatf("port %0d read data", p), exp, rrsp_data[p]);
      end
      hold_prev[p] = rrsp_valid[p] && !rrsp_ready[p];
      held_data[p] = rrsp_data[p];
      // Slot free or draining, target not in flight
      exp_rdy = (exp_q[p].size() == 0) && !model_busy(rreq_addr[p]);
      check_value($sformatf("port %0d request ready", p), vrf_data_t'(exp_rdy),
                  vrf_data_t'(rreq_ready[p]));
      r_acc = rreq_valid[p] && rreq_ready[p];
      if (r_acc) begin
        // Snapshot before this edge's write lands
        exp_q[p].push_back(model_mem[rreq_addr[p]]);
        nxt_rvalid[p] = 1'b0;
      end
      acc_prev[p] = r_acc;
    end
    check_value("write ready", vrf_data_t'(1'b1), vrf_data_t'(wreq_ready));
    if (wreq_valid && wreq_ready) begin
      model_write(wreq.addr, wreq.data, wreq.strb);
      nxt_wvalid = 1'b0;
    end
    model_advance(wreq_valid && wreq_ready, wreq.addr);
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic tick();
    @(negedge clk);
    wreq_valid = nxt_wvalid;
    wreq       = nxt_wreq;
    rreq_valid = nxt_rvalid;
    rreq_addr  = nxt_raddr;
    rrsp_ready = nxt_rrdy;
    #1;
    observe();
  endtask

  function automatic vrf_data_t rand_word();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  // Never empty, the array rejects a write with no lane
  function automatic vrf_strb_t rand_strb();
    vrf_strb_t s;
    s = vrf_strb_t'($urandom);
    if (s == '0) begin
      s = '1;
    end
    return s;
  endfunction

  function automatic logic all_idle();
    logic idle;
    idle = !nxt_wvalid && (nxt_rvalid == '0) && !fl_valid[0] && !fl_valid[1];
    for (int p = 0; p < NrPorts; p++) begin
      idle = idle && (exp_q[p].size() == 0);
    end
    return idle;
  endfunction

  task automatic drain();
    int n;
    nxt_rrdy = '1;
    n = 0;
    while (!all_idle() && n < 64) begin
      tick();
      n++;
    end
    if (!all_idle()) begin
      report_error("traffic did not drain");
    end
  endtask

  task automatic write_word(input vreg_addr_t addr, input vrf_data_t data, input vrf_strb_t strb);
    nxt_wvalid = 1'b1;
    nxt_wreq   = '{addr: addr, data: data, strb: strb};
    tick();
    while (nxt_wvalid) begin
      tick();
    end
  endtask

  task automatic read_pair(input vreg_addr_t a0, input vreg_addr_t a1);
    nxt_rvalid = '1;
    nxt_raddr  = {a1, a0};
    tick();
    while (nxt_rvalid != '0) begin
      tick();
    end
  endtask

  // Requests held until taken, random response back-pressure
  task automatic run_traffic(input int cycles, input vreg_addr_t mask, input int rdy_pct);
    for (int c = 0; c < cycles; c++) begin
      if (!nxt_wvalid && ($urandom % 100) < 50) begin
        nxt_wvalid = 1'b1;
        nxt_wreq   = '{addr: vreg_addr_t'($urandom) & mask, data: rand_word(), strb: rand_strb()};
      end
      for (int p = 0; p < NrPorts; p++) begin
        if (!nxt_rvalid[p] && ($urandom % 100) < 60) begin
          nxt_rvalid[p] = 1'b1;
          nxt_raddr[p]  = vreg_addr_t'($urandom) & mask;
        end
        nxt_rrdy[p] = ($urandom % 100) < rdy_pct;
      end
      tick();
    end
    drain();
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic start_test(input string name);
    test_name = name;
    test_errs = err_count;
  endtask

  task automatic finish_test();
    if (err_count == test_errs) begin
      $display("test %s: ok", test_name);
    end else begin
      $display("test %s: %0d error(s)", test_name, err_count - test_errs);
    end
  endtask

  task automatic reset_and_zero_fill();
    int waited;
    repeat (2) @(posedge clk);
    #1;
    check_value("ready in reset", '0, vrf_data_t'(wreq_ready));
    check_value("response valid in reset", '0, vrf_data_t'(rrsp_valid));
    @(negedge clk);
    arst_n = 1'b1;
    waited = 0;
    while (!wreq_ready && waited < 4) begin
      @(negedge clk);
      #1;
      waited++;
    end
    check_value("ready after reset", vrf_data_t'(1'b1), vrf_data_t'(wreq_ready));
    check_value("response valid after reset", '0, vrf_data_t'(rrsp_valid));
    for (int r = 0; r < NrVregs; r++) begin
      write_word(vreg_addr_t'(r), '0, '1);
    end
    for (int r = 0; r < NrVregs; r++) begin
      read_pair(vreg_addr_t'(r), vreg_addr_t'(r));
    end
    drain();
  endtask

  task automatic full_word_writes();
    for (int r = 0; r < NrVregs; r++) begin
      write_word(vreg_addr_t'(r), rand_word(), '1);
    end
    for (int r = 0; r < NrVregs; r++) begin
      read_pair(vreg_addr_t'(r), vreg_addr_t'(NrVregs - 1 - r));
    end
    drain();
  endtask

  task automatic read_after_write();
    vreg_addr_t a;
    for (int i = 0; i < 8; i++) begin
      a = vreg_addr_t'($urandom);
      // Both ports meet the write on its accepting edge
      nxt_wvalid = 1'b1;
      nxt_wreq   = '{addr: a, data: rand_word(), strb: rand_strb()};
      nxt_rvalid = '1;
      nxt_raddr  = {a, a};
      tick();
      // Again while it is in flight
      nxt_rvalid = '1;
      tick();
      while (nxt_rvalid != '0) begin
        tick();
      end
      drain();
    end
    // Four registers only, hazards on most cycles
    run_traffic(RawCycles, 5'h03, 100);
  endtask

  initial begin
    void'($urandom(80));
    arst_n      = 1'b0;
    wreq_valid  = 1'b0;
    wreq        = '0;
    rreq_valid  = '0;
    rreq_addr   = '0;
    rrsp_ready  = '1;
    nxt_wvalid  = 1'b0;
    nxt_wreq    = '0;
    nxt_rvalid  = '0;
    nxt_raddr   = '0;
    nxt_rrdy    = '1;
    acc_prev    = '0;
    hold_prev   = '0;
    err_count   = 0;
    check_count = 0;
    model_clear();

    start_test("reset");
    reset_and_zero_fill();
    finish_test();
    start_test("full_writes");
    full_word_writes();
    finish_test();
    start_test("byte_masks");
    run_traffic(MaskCycles, '1, 100);
    finish_test();
    start_test("read_after_write");
    read_after_write();
    finish_test();
    start_test("back_pressure");
    run_traffic(BpCycles, '1, 30);
    finish_test();
    start_test("random_traffic");
    run_traffic(RandCycles, '1, 70);
    finish_test();

    $display("Summary: %0d checks, %0d errors", check_count, err_count);
    if (err_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+tb
rtl/vrf_pkg.sv
rtl/vrf_clk_gate.sv
rtl/vregfile.sv
rtl/vrf_write_port.sv
rtl/vrf_read_port.sv
rtl/vrf_top.sv
tb/tb_vrf_top.sv

// File: Makefile
TOP  := tb_vrf_top
SIM  := obj_dir/V$(TOP)
SRCS := $(filter-out +%,$(shell cat flist.f)) tb/tb_vrf_model.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): flist.f $(SRCS)
	verilator --binary --assert --timing --timescale 1ns/1ps \
		-f flist.f --top-module $(TOP) -o V$(TOP)

run: $(SIM)
	./$(SIM) | tee sim.log
	@grep -q "^All tests passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
